// File: axi_protocol.f
axi_field_pkg.sv
axi_chan_pkg.sv
axi_addr_channel.sv
axi_burst_tracker.sv
axi_wdata_channel.sv
axi_bresp_channel.sv
axi_protocol.sv
tb_axi_protocol.sv

// File: Makefile
# Verilator build and run for the AXI write channel model

VERILATOR ?= verilator
TOP       ?= tb_axi_protocol
FILELIST  ?= axi_protocol.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_axi_protocol.sv
//####################
// testbench for the AXI write channel model
// directed tests against a handshake monitor
//####################

module tb_axi_protocol;
   import axi_field_pkg::*;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 6;
   localparam int HS_TIMEOUT = 100;   // cycles allowed per handshake
   localparam int AW_CH      = 0;
   localparam int W_CH       = 1;
   localparam int B_CH       = 2;

   logic    axi_aclk = 1'b0;
   logic    rst;
   aw_req_t aw_in;
   logic    awvalid_in;
   w_beat_t w_in;
   logic    wvalid_in;
   logic    wready_in;
   logic    bready_in;
   aw_req_t axi_aw;
   logic    axi_awvalid;
   logic    axi_awready;
   w_beat_t axi_w;
   logic    axi_wvalid;
   logic    axi_wready;
   logic    axi_wlast;
   resp_e   axi_bresp;
   logic    axi_bvalid;
   logic    axi_bready;

   int      cyc = 0;
   int      errors = 0;
   int      tests_failed = 0;
   int      test_err_base;
   int      aw_drive_cyc;
   int      aw_hs_cyc;
   int      b_hs_cyc;
   int      aw_base;
   int      w_base;
   int      b_base;

   // handshake records from the monitor
   aw_req_t aw_seen[$];
   w_beat_t w_seen[$];
   logic    last_seen[$];
   resp_e   b_seen[$];
   w_beat_t exp_beats[$];
   logic    exp_last[$];

   axi_protocol i_axi_protocol (.*);

   always #(CLK_PERIOD / 2) axi_aclk = ~axi_aclk;

   always @(posedge axi_aclk) cyc <= cyc + 1;

   //####################
   // handshake monitor at the falling edge
   //####################
   always @(negedge axi_aclk) begin
      if (!rst) begin
         if (axi_awvalid && axi_awready) begin
            aw_seen.push_back(axi_aw);
            aw_hs_cyc = cyc;
         end
         if (axi_wvalid && axi_wready) begin
            w_seen.push_back(axi_w);
            last_seen.push_back(axi_wlast);
         end
         if (axi_bvalid && axi_bready) begin
            b_seen.push_back(axi_bresp);
            b_hs_cyc = cyc;
         end
      end
   end

   task automatic compare_aw(input string name, input aw_req_t got, input aw_req_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_beat(input string name, input w_beat_t got, input w_beat_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_resp(input string name, input resp_e got, input resp_e exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("ERROR %s", msg);
      errors++;
   endtask

   task automatic next_cycle();
      @(posedge axi_aclk);
      #1;   // drive just after the edge
   endtask

   function automatic int hs_count(input int chan);
      case (chan)
         AW_CH:   return aw_seen.size() - aw_base;
         W_CH:    return w_seen.size() - w_base;
         default: return b_seen.size() - b_base;
      endcase
   endfunction

   function automatic aw_req_t make_req(input logic [31:0] addr, input logic [7:0] len);
      aw_req_t r;
      r.addr  = addr;
      r.len   = len;
      r.size  = 3'd3;   // 8 bytes per beat
      r.burst = INCR;
      return r;
   endfunction

   function automatic w_beat_t random_beat();
      w_beat_t b;
      b.data = {$urandom, $urandom};
      b.strb = 8'($urandom);
      return b;
   endfunction

   task automatic start_test();
      test_err_base = errors;
      aw_base = aw_seen.size();
      w_base  = w_seen.size();
      b_base  = b_seen.size();
      exp_beats.delete();
      exp_last.delete();
   endtask

   task automatic close_test(input string name);
      if (errors == test_err_base) begin
         $display("test %s: pass", name);
      end else begin
         $display("test %s: FAIL with %0d errors", name, errors - test_err_base);
         tests_failed++;
      end
   endtask

   task automatic wait_handshakes(input int chan, input int n, input string what);
      int waited;
      waited = 0;
      while (hs_count(chan) < n && waited < HS_TIMEOUT) begin
         next_cycle();
         waited++;
      end
      if (hs_count(chan) < n) begin
         report_failure($sformatf("no %s handshake within %0d cycles", what, HS_TIMEOUT));
      end
   endtask

   task automatic pulse_aw(input aw_req_t req);
      aw_in        = req;
      awvalid_in   = 1'b1;
      aw_drive_cyc = cyc;
      next_cycle();
      awvalid_in   = 1'b0;
      aw_in        = ~req;   // held request must not follow the input
   endtask

   // one beat strobe with slave ready held low for gap cycles
   task automatic send_beat(input w_beat_t beat, input int gap);
      int n;
      n = hs_count(W_CH);
      w_in      = beat;
      wvalid_in = 1'b1;
      if (gap > 0) begin
         wready_in = 1'b0;
      end
      next_cycle();
      wvalid_in = 1'b0;
      w_in      = ~beat;   // registered beat must not follow the input
      if (gap > 0) begin
         repeat (gap) begin
            compare_bit("axi_wvalid", axi_wvalid, 1'b1);
            compare_bit("axi_wready", axi_wready, 1'b0);
            compare_beat("axi_w", axi_w, beat);
            next_cycle();
         end
         if (hs_count(W_CH) != n) begin
            report_failure("write beat accepted while wready_in was low");
         end
         wready_in = 1'b1;
      end
      wait_handshakes(W_CH, n + 1, "write data");
   endtask

   task automatic send_beats(input int len, input int max_gap);
      w_beat_t beat;
      int      gap;
      for (int i = 0; i <= len; i++) begin
         beat = random_beat();
         gap  = (max_gap > 0) ? 1 + int'($urandom % max_gap) : 0;
         exp_beats.push_back(beat);
         exp_last.push_back(i == len);
         send_beat(beat, gap);
      end
   endtask

   task automatic check_beats();
      if (hs_count(W_CH) != exp_beats.size()) begin
         report_failure($sformatf("saw %0d write beats where %0d were sent",
                                  hs_count(W_CH), exp_beats.size()));
      end else begin
         foreach (exp_beats[i]) begin
            compare_beat("axi_w", w_seen[w_base + i], exp_beats[i]);
            compare_bit("axi_wlast", last_seen[w_base + i], exp_last[i]);
         end
      end
   endtask

   task automatic check_responses(input int n);
      if (hs_count(B_CH) != n) begin
         report_failure($sformatf("saw %0d response handshakes instead of %0d",
                                  hs_count(B_CH), n));
      end else begin
         for (int i = 0; i < n; i++) begin
            compare_resp("axi_bresp", b_seen[b_base + i], OKAY);
         end
      end
   endtask

   //####################
   // directed tests
   //####################
   task automatic check_reset_state();
      start_test();
      compare_bit("axi_awvalid", axi_awvalid, 1'b0);
      compare_bit("axi_awready", axi_awready, 1'b1);   // free channel
      compare_bit("axi_wvalid", axi_wvalid, 1'b0);
      compare_bit("axi_wready", axi_wready, 1'b0);
      compare_bit("axi_wlast", axi_wlast, 1'b0);
      compare_bit("axi_bvalid", axi_bvalid, 1'b0);
      compare_bit("axi_bready", axi_bready, 1'b0);
      close_test("reset state");
   endtask

   task automatic single_beat_write();
      aw_req_t req;
      start_test();
      req       = make_req(32'h1000_0040, 8'd0);
      bready_in = 1'b1;
      wready_in = 1'b1;
      pulse_aw(req);
      wait_handshakes(AW_CH, 1, "address");
      if (hs_count(AW_CH) == 1) begin
         compare_aw("axi_aw", aw_seen[aw_base], req);
         if (aw_hs_cyc != aw_drive_cyc + 1) begin
            report_failure("address handshake not one cycle after awvalid_in");
         end
      end
      send_beats(0, 0);
      wait_handshakes(B_CH, 1, "response");
      check_beats();
      check_responses(1);
      close_test("single beat write");
   endtask

   task automatic four_beat_burst();
      start_test();
      bready_in = 1'b1;
      wready_in = 1'b1;
      pulse_aw(make_req(32'h1000_0100, 8'd3));
      wait_handshakes(AW_CH, 1, "address");
      send_beats(3, 0);
      wait_handshakes(B_CH, 1, "response");
      repeat (3) next_cycle();   // no extra beats may follow
      check_beats();
      check_responses(1);
      close_test("four beat burst");
   endtask

   task automatic data_backpressure();
      start_test();
      bready_in = 1'b1;
      wready_in = 1'b0;
      pulse_aw(make_req(32'h1800_0000, 8'd4));
      wait_handshakes(AW_CH, 1, "address");
      send_beats(4, 4);
      wait_handshakes(B_CH, 1, "response");
      check_beats();
      check_responses(1);
      close_test("data back-pressure");
   endtask

   task automatic address_blocking();
      aw_req_t req1;
      aw_req_t req2;
      start_test();
      req1      = make_req(32'h2000_0000, 8'd1);
      req2      = make_req(32'h2000_1000, 8'd0);
      bready_in = 1'b0;
      wready_in = 1'b1;
      pulse_aw(req1);
      wait_handshakes(AW_CH, 1, "address");
      pulse_aw(req2);   // lands inside the open burst
      compare_bit("axi_awvalid", axi_awvalid, 1'b1);
      compare_bit("axi_awready", axi_awready, 1'b0);
      send_beats(1, 0);
      repeat (3) begin
         compare_bit("axi_awvalid", axi_awvalid, 1'b1);
         compare_bit("axi_awready", axi_awready, 1'b0);
         compare_aw("axi_aw", axi_aw, req2);
         next_cycle();
      end
      if (hs_count(AW_CH) != 1) begin
         report_failure("second address accepted before the first response");
      end
      bready_in = 1'b1;
      wait_handshakes(B_CH, 1, "response");
      wait_handshakes(AW_CH, 2, "second address");
      if (hs_count(AW_CH) == 2) begin
         compare_aw("axi_aw", aw_seen[aw_base], req1);
         compare_aw("axi_aw", aw_seen[aw_base + 1], req2);
         if (aw_hs_cyc <= b_hs_cyc) begin
            report_failure("second address handshake did not follow the response");
         end
      end
      send_beats(0, 0);
      wait_handshakes(B_CH, 2, "second response");
      check_beats();
      check_responses(2);
      close_test("address blocking");
   endtask

   task automatic response_backpressure();
      int hold;
      start_test();
      bready_in = 1'b0;
      wready_in = 1'b1;
      pulse_aw(make_req(32'h3000_0100, 8'd2));
      wait_handshakes(AW_CH, 1, "address");
      send_beats(2, 0);
      hold = 2 + int'($urandom % 6);
      repeat (hold) begin
         compare_bit("axi_bvalid", axi_bvalid, 1'b1);
         compare_bit("axi_bready", axi_bready, 1'b0);
         compare_resp("axi_bresp", axi_bresp, OKAY);
         next_cycle();
      end
      if (hs_count(B_CH) != 0) begin
         report_failure("response handshake while bready_in was low");
      end
      bready_in = 1'b1;
      wait_handshakes(B_CH, 1, "response");
      repeat (3) next_cycle();
      check_beats();
      check_responses(1);
      close_test("response back-pressure");
   endtask

   //####################
   // main sequence
   //####################
   initial begin
      void'($urandom(24171));
      rst        = 1'b1;
      aw_in      = '0;
      awvalid_in = 1'b0;
      w_in       = '0;
      wvalid_in  = 1'b0;
      wready_in  = 1'b0;
      bready_in  = 1'b0;
      repeat (5) @(posedge axi_aclk);
      #1;
      rst = 1'b0;
      check_reset_state();
      single_beat_write();
      four_beat_burst();
      data_backpressure();
      address_blocking();
      response_backpressure();
      $display("tests run %0d, tests failed %0d, check errors %0d",
               NUM_TESTS, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // run limit from the test count
   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("ERROR watchdog expired after %0d cycles", NUM_TESTS * 200);
      $display("Test failures found");
      $finish;
   end

endmodule

// File: axi_protocol.sv
//####################
// AXI write channel model
// address, burst tracking, data and
// response blocks wired together
//####################

module axi_protocol (
   input  logic                   axi_aclk,
   input  logic                   rst,
   input  axi_field_pkg::aw_req_t aw_in,
   input  logic                   awvalid_in,
   input  axi_field_pkg::w_beat_t w_in,
   input  logic                   wvalid_in,
   input  logic                   wready_in,
   input  logic                   bready_in,
   output axi_field_pkg::aw_req_t axi_aw,
   output logic                   axi_awvalid,
   output logic                   axi_awready,
   output axi_field_pkg::w_beat_t axi_w,
   output logic                   axi_wvalid,
   output logic                   axi_wready,
   output logic                   axi_wlast,
   output axi_field_pkg::resp_e   axi_bresp,
   output logic                   axi_bvalid,
   output logic                   axi_bready
);

   logic aw_commit;      // address handshake cycle
   logic w_commit;       // data handshake cycle
   logic burst_open;
   logic resp_pending;

   axi_addr_channel i_addr_channel (
      .axi_aclk     (axi_aclk),
      .rst          (rst),
      .aw_in        (aw_in),
      .awvalid_in   (awvalid_in),
      .burst_open   (burst_open),
      .resp_pending (resp_pending),
      .axi_aw       (axi_aw),
      .axi_awvalid  (axi_awvalid),
      .axi_awready  (axi_awready),
      .aw_commit    (aw_commit)
   );

   axi_burst_tracker i_burst_tracker (
      .axi_aclk   (axi_aclk),
      .rst        (rst),
      .aw_commit  (aw_commit),
      .aw_len     (axi_aw.len),   // request held during the handshake
      .w_commit   (w_commit),
      .burst_open (burst_open),
      .axi_wlast  (axi_wlast)
   );

   axi_wdata_channel i_wdata_channel (
      .axi_aclk   (axi_aclk),
      .rst        (rst),
      .w_in       (w_in),
      .wvalid_in  (wvalid_in),
      .wready_in  (wready_in),
      .burst_open (burst_open),
      .axi_wlast  (axi_wlast),
      .axi_w      (axi_w),
      .axi_wvalid (axi_wvalid),
      .axi_wready (axi_wready),
      .w_commit   (w_commit)
   );

   axi_bresp_channel i_bresp_channel (
      .axi_aclk     (axi_aclk),
      .rst          (rst),
      .w_commit     (w_commit),
      .axi_wlast    (axi_wlast),
      .bready_in    (bready_in),
      .axi_bresp    (axi_bresp),
      .axi_bvalid   (axi_bvalid),
      .axi_bready   (axi_bready),
      .resp_pending (resp_pending)
   );

endmodule

// File: axi_bresp_channel.sv
//####################
// AXI write response channel
// OKAY after the last beat, holds off
// new addresses until it is taken
//####################

module axi_bresp_channel (
   input  logic                 axi_aclk,
   input  logic                 rst,
   input  logic                 w_commit,
   input  logic                 axi_wlast,
   input  logic                 bready_in,
   output axi_field_pkg::resp_e axi_bresp,
   output logic                 axi_bvalid,
   output logic                 axi_bready,
   output logic                 resp_pending
);
   import axi_field_pkg::*;
   import axi_chan_pkg::*;

   chan_state_e b_state;
   logic        last_done;   // final beat accepted

   assign last_done    = w_commit & axi_wlast;
   assign resp_pending = (b_state != CH_WAIT);   // through the handshake cycle

   always_ff @(posedge axi_aclk) begin
      if (last_done) begin
         axi_bresp <= OKAY;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         b_state    <= CH_WAIT;
         axi_bvalid <= 1'b0;
         axi_bready <= 1'b0;
      end else begin
         case (b_state)
            CH_WAIT: begin
               if (last_done) begin
                  axi_bvalid <= 1'b1;
                  axi_bready <= bready_in;
                  if (bready_in) begin
                     b_state <= CH_COMMIT;
                  end else begin
                     b_state <= CH_ASSERT;
                  end
               end
            end
            CH_COMMIT: begin
               axi_bvalid <= 1'b0;   // response taken
               axi_bready <= 1'b0;
               b_state    <= CH_WAIT;
            end
            CH_ASSERT: begin
               if (bready_in) begin
                  axi_bready <= 1'b1;
                  b_state    <= CH_COMMIT;
               end
            end
            default: begin
               axi_bvalid <= 1'b0;
               axi_bready <= 1'b0;
               b_state    <= CH_WAIT;
            end
         endcase
      end
   end

   a_bready_valid: assert property (@(posedge axi_aclk) disable iff (rst)
      axi_bready |-> axi_bvalid)
      else $error("response ready raised with no valid response");

endmodule

// File: axi_wdata_channel.sv
//####################
// AXI write data channel
// registers beats and mirrors the slave
// ready while a burst is open
//####################

module axi_wdata_channel (
   input  logic                   axi_aclk,
   input  logic                   rst,
   input  axi_field_pkg::w_beat_t w_in,
   input  logic                   wvalid_in,
   input  logic                   wready_in,
   input  logic                   burst_open,
   input  logic                   axi_wlast,
   output axi_field_pkg::w_beat_t axi_w,
   output logic                   axi_wvalid,
   output logic                   axi_wready,
   output logic                   w_commit
);
   import axi_chan_pkg::*;

   chan_state_e w_state;
   logic        slave_ready;   // slave ready inside a burst
   logic        capture;

   assign slave_ready = burst_open & wready_in;
   assign w_commit    = (w_state == CH_COMMIT);

   // new beat can be taken during a handshake cycle
   assign capture = wvalid_in & (w_state != CH_ASSERT);

   always_ff @(posedge axi_aclk) begin
      if (capture) begin
         axi_w <= w_in;
      end
   end

   //####################
   // handshake FSM
   //####################
   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         w_state    <= CH_WAIT;
         axi_wvalid <= 1'b0;
         axi_wready <= 1'b0;
      end else begin
         case (w_state)
            CH_WAIT: begin
               if (wvalid_in) begin
                  axi_wvalid <= 1'b1;
                  if (slave_ready) begin
                     axi_wready <= 1'b1;
                     w_state    <= CH_COMMIT;
                  end else begin
                     axi_wready <= 1'b0;
                     w_state    <= CH_ASSERT;
                  end
               end
            end
            CH_COMMIT: begin
               if (axi_wlast) begin
                  // burst closes, next beat waits for a new address
                  axi_wready <= 1'b0;
                  axi_wvalid <= wvalid_in;
                  if (wvalid_in) begin
                     w_state <= CH_ASSERT;
                  end else begin
                     w_state <= CH_WAIT;
                  end
               end else if (wvalid_in) begin
                  axi_wready <= slave_ready;   // back to back beats
                  if (slave_ready) begin
                     w_state <= CH_COMMIT;
                  end else begin
                     w_state <= CH_ASSERT;
                  end
               end else begin
                  axi_wvalid <= 1'b0;
                  axi_wready <= 1'b0;
                  w_state    <= CH_WAIT;
               end
            end
            CH_ASSERT: begin
               if (slave_ready) begin
                  axi_wready <= 1'b1;
                  w_state    <= CH_COMMIT;
               end
            end
            default: begin
               axi_wvalid <= 1'b0;
               axi_wready <= 1'b0;
               w_state    <= CH_WAIT;
            end
         endcase
      end
   end

   // ready is only shown against a held beat
   a_wready_valid: assert property (@(posedge axi_aclk) disable iff (rst)
      axi_wready |-> axi_wvalid)
      else $error("write ready raised with no valid beat");

endmodule

// File: axi_burst_tracker.sv
//####################
// AXI write burst tracker
// opens a burst on the address handshake,
// counts beats down and flags the last one
//####################

module axi_burst_tracker (
   input  logic                               axi_aclk,
   input  logic                               rst,
   input  logic                               aw_commit,
   input  logic [axi_field_pkg::LEN_WIDTH-1:0] aw_len,
   input  logic                               w_commit,
   output logic                               burst_open,
   output logic                               axi_wlast
);
   import axi_field_pkg::*;

   logic [LEN_WIDTH-1:0] beats_left;   // beats after the current one

   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         burst_open <= 1'b0;
         axi_wlast  <= 1'b0;
         beats_left <= '0;
      end else if (aw_commit) begin
         burst_open <= 1'b1;
         beats_left <= aw_len;
         axi_wlast  <= (aw_len == '0);   // single beat burst
      end else if (w_commit) begin
         if (axi_wlast) begin
            // last beat accepted, burst is done
            burst_open <= 1'b0;
            axi_wlast  <= 1'b0;
         end else begin
            beats_left <= beats_left - LEN_WIDTH'(1);
            axi_wlast  <= (beats_left == LEN_WIDTH'(1));   // next beat is final
         end
      end
   end

   // data handshakes only happen inside an open burst
   a_beat_in_burst: assert property (@(posedge axi_aclk) disable iff (rst)
      w_commit |-> burst_open)
      else $error("write beat accepted with no open burst");

endmodule

// File: axi_addr_channel.sv
//####################
// AXI write address channel
// registers the upstream request, raises
// valid and ready, marks the handshake
//####################

module axi_addr_channel (
   input  logic                   axi_aclk,
   input  logic                   rst,
   input  axi_field_pkg::aw_req_t aw_in,
   input  logic                   awvalid_in,
   input  logic                   burst_open,
   input  logic                   resp_pending,
   output axi_field_pkg::aw_req_t axi_aw,
   output logic                   axi_awvalid,
   output logic                   axi_awready,
   output logic                   aw_commit
);
   import axi_chan_pkg::*;

   chan_state_e aw_state;
   logic        chan_free;     // no burst, no response outstanding
   logic        capture;

   assign chan_free = ~burst_open & ~resp_pending;
   assign aw_commit = (aw_state == CH_COMMIT);   // valid and ready both high

   // request is taken in wait and during a handshake, held while asserting
   assign capture = awvalid_in & (aw_state != CH_ASSERT);

   always_ff @(posedge axi_aclk) begin
      if (capture) begin
         axi_aw <= aw_in;
      end
   end

   //####################
   // handshake FSM
   //####################
   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         aw_state    <= CH_WAIT;
         axi_awvalid <= 1'b0;
         axi_awready <= 1'b1;   // channel free out of reset
      end else begin
         case (aw_state)
            CH_WAIT: begin
               axi_awready <= chan_free;   // rests high while idle
               if (awvalid_in) begin
                  axi_awvalid <= 1'b1;
                  if (chan_free) begin
                     aw_state <= CH_COMMIT;
                  end else begin
                     aw_state <= CH_ASSERT;
                  end
               end
            end
            CH_COMMIT: begin
               axi_awready <= 1'b0;
               if (awvalid_in) begin
                  axi_awvalid <= 1'b1;   // next request waits for the burst
                  aw_state    <= CH_ASSERT;
               end else begin
                  axi_awvalid <= 1'b0;
                  aw_state    <= CH_WAIT;
               end
            end
            CH_ASSERT: begin
               if (chan_free) begin
                  axi_awready <= 1'b1;
                  aw_state    <= CH_COMMIT;
               end
            end
            default: begin
               axi_awvalid <= 1'b0;
               axi_awready <= 1'b0;
               aw_state    <= CH_WAIT;
            end
         endcase
      end
   end

   // a stalled request keeps valid and payload until it is accepted
   a_aw_hold: assert property (@(posedge axi_aclk) disable iff (rst)
      axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_aw))
      else $error("write address changed or dropped before handshake");

endmodule

// File: axi_chan_pkg.sv
//####################
// AXI channel handshake states
// shared by the address, data and
// response channel machines
//####################

package axi_chan_pkg;

   // valid low, waiting for upstream
   // valid and ready both high, handshake cycle
   // valid high, waiting for ready
   typedef enum logic [1:0] {
      CH_WAIT   = 2'b00,
      CH_COMMIT = 2'b01,
      CH_ASSERT = 2'b10
   } chan_state_e;

endpackage

// File: axi_field_pkg.sv
//####################
// AXI write field definitions
// bus widths, burst and response codes,
// packed address request and data beat
//####################

package axi_field_pkg;

   localparam int unsigned ADDR_WIDTH = 32;             // byte address
   localparam int unsigned DATA_WIDTH = 64;             // write data bus
   localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8; // one strobe per byte
   localparam int unsigned LEN_WIDTH  = 8;              // beats minus one
   localparam int unsigned SIZE_WIDTH = 3;              // log2 bytes per beat

   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } burst_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_e;

   // write address request, 45 bits
   typedef struct packed {
      logic [ADDR_WIDTH-1:0] addr;
      logic [LEN_WIDTH-1:0]  len;   // burst length minus one
      logic [SIZE_WIDTH-1:0] size;
      burst_e                burst;
   } aw_req_t;

   // one write data beat, 72 bits
   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic [STRB_WIDTH-1:0] strb;
   } w_beat_t;

endpackage
